// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_sa_controller
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= TESTS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== all.f ====
src/sa_ctrl_pkg.sv
src/sa_ctrl_if.sv
src/sa_ctrl_fsm.sv
src/sa_ctrl_counters.sv
src/sa_rom_cfg_regs.sv
src/sa_row_col_gen.sv
src/sa_controller.sv
tests/tb_sa_controller.sv

// ==== src/sa_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module sa_controller (
    input  wire                                                     clk_i,
    input  wire                                                     sel_mux_tr_rst,
    input  wire                                                     halt_i,
    input  wire                                                     end_feature_i,
    input  wire  [sa_ctrl_pkg::NUM_COL_W-1:0]                       filter_size_i,
    input  wire  [sa_ctrl_pkg::ROUND_W-1:0]                         max_round_weight_i,
    input  wire  [sa_ctrl_pkg::ROM_W-1:0]                           rom_signals_data_i,
    output logic                                                    rst_o,
    output logic                                                    load_o,
    output logic                                                    ready_o,
    output logic                                                    start_op_o,
    output logic                                                    rd_feature_ld_o,
    output logic [sa_ctrl_pkg::ROM_ADDR_W-1:0]                      addrs_rom_signal_o,
    output logic [sa_ctrl_pkg::FEAT_ADDR_W-1:0]                     in_feature_addr_o,
    output logic [sa_ctrl_pkg::N_ROWS-1:0][sa_ctrl_pkg::SEL_W-1:0]     f_sel_o,
    output logic [sa_ctrl_pkg::N_ROWS-1:0][sa_ctrl_pkg::NUM_COL_W-1:0] number_of_columns_o,
    output logic [sa_ctrl_pkg::N_ROWS-1:0][sa_ctrl_pkg::TR_SEL_W-1:0]  sel_mux_tr_o,
    output logic [sa_ctrl_pkg::N_ROWS-1:0]                          en_adder_node_o,
    output logic [sa_ctrl_pkg::N_ROWS-1:0][sa_ctrl_pkg::NUM_COL_W-1:0] column_num_o,
    output logic [sa_ctrl_pkg::N_ROWS-1:0][sa_ctrl_pkg::NUM_COL_W-1:0] row_num_o,
    output logic [sa_ctrl_pkg::N_ROWS-1:0]                          sel_mux_node_o
);

    sa_ctrl_if ctl_if ();

    sa_ctrl_fsm u_fsm (
        .clk_i           (clk_i),
        .sel_mux_tr_rst  (sel_mux_tr_rst),
        .halt_i          (halt_i),
        .end_feature_i   (end_feature_i),
        .ctl             (ctl_if.fsm),
        .rst_o           (rst_o),
        .load_o          (load_o),
        .ready_o         (ready_o),
        .start_op_o      (start_op_o),
        .rd_feature_ld_o (rd_feature_ld_o)
    );

    sa_ctrl_counters u_counters (
        .clk_i              (clk_i),
        .sel_mux_tr_rst     (sel_mux_tr_rst),
        .ctl                (ctl_if.cnt),
        .filter_size_i      (filter_size_i),
        .max_round_weight_i (max_round_weight_i),
        .rom_addr_o         (addrs_rom_signal_o),
        .in_feature_addr_o  (in_feature_addr_o)
    );

    sa_rom_cfg_regs u_cfg_regs (
        .clk_i               (clk_i),
        .sel_mux_tr_rst      (sel_mux_tr_rst),
        .ctl                 (ctl_if.cfg),
        .rom_signals_data_i  (rom_signals_data_i),
        .f_sel_o             (f_sel_o),
        .number_of_columns_o (number_of_columns_o),
        .sel_mux_tr_o        (sel_mux_tr_o),
        .en_adder_node_o     (en_adder_node_o)
    );

    sa_row_col_gen u_row_col (
        .clk_i              (clk_i),
        .sel_mux_tr_rst     (sel_mux_tr_rst),
        .ctl                (ctl_if.cfg),
        .rom_signals_data_i (rom_signals_data_i),
        .filter_size_i      (filter_size_i),
        .column_num_o       (column_num_o),
        .row_num_o          (row_num_o),
        .sel_mux_node_o     (sel_mux_node_o)
    );

endmodule

`default_nettype wire

// ==== src/sa_ctrl_counters.sv ====
`timescale 1ns/1ps
`default_nettype none

module sa_ctrl_counters (
    input  wire                                  clk_i,
    input  wire                                  sel_mux_tr_rst,
    sa_ctrl_if.cnt                               ctl,
    input  wire  [sa_ctrl_pkg::NUM_COL_W-1:0]    filter_size_i,
    input  wire  [sa_ctrl_pkg::ROUND_W-1:0]      max_round_weight_i,
    output logic [sa_ctrl_pkg::ROM_ADDR_W-1:0]   rom_addr_o,
    output logic [sa_ctrl_pkg::FEAT_ADDR_W-1:0]  in_feature_addr_o
);

    logic [sa_ctrl_pkg::LOAD_W-1:0]    load_cnt;
    logic [sa_ctrl_pkg::READY_W-1:0]   ready_cnt;
    logic [sa_ctrl_pkg::WAIT_W-1:0]    wait_cnt;
    logic [sa_ctrl_pkg::ROUND_W-1:0]   round_cnt;
    logic [sa_ctrl_pkg::NUM_COL_W-1:0] fs_m1;
    logic [sa_ctrl_pkg::WAIT_W-1:0]    wait_last;
    logic                              load_last;

    ////////////////////////////////////////////////////////////////////////////
    // counters
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or posedge sel_mux_tr_rst) begin
        if (sel_mux_tr_rst) begin
            load_cnt          <= '0;
            ready_cnt         <= '0;
            wait_cnt          <= '0;
            round_cnt         <= '0;
            in_feature_addr_o <= '0;
        end else begin
            if (ctl.load_cnt_clr) begin
                load_cnt <= '0;
            end else if (ctl.load_cnt_ld) begin
                load_cnt <= load_cnt + 1'b1;
            end
            if (ctl.ready_cnt_clr) begin
                ready_cnt <= '0;
            end else if (ctl.ready_cnt_ld) begin
                ready_cnt <= ready_cnt + 1'b1;
            end
            if (ctl.wait_cnt_clr) begin
                wait_cnt <= '0;
            end else if (ctl.wait_cnt_ld) begin
                wait_cnt <= wait_cnt + 1'b1;
            end
            // one weight round per completed load phase
            if (ctl.round_clr) begin
                round_cnt <= '0;
            end else if (load_last) begin
                round_cnt <= round_cnt + 1'b1;
            end
            if (ctl.feat_clr) begin
                in_feature_addr_o <= '0;
            end else if (ctl.feat_ld) begin
                in_feature_addr_o <= in_feature_addr_o + 1'b1;
            end
        end
    end

    // round * N_COLS + load count
    assign rom_addr_o = {round_cnt, load_cnt};

    // drain ends at 2*(filter_size-1) + base
    assign fs_m1     = filter_size_i - 1'b1;
    assign wait_last = {1'b0, fs_m1, 1'b0} + sa_ctrl_pkg::DRAIN_BASE;

    assign load_last      = (load_cnt == sa_ctrl_pkg::LOAD_LAST);
    assign ctl.load_done  = load_last;
    assign ctl.ready_done = (ready_cnt == sa_ctrl_pkg::READY_LAST);
    assign ctl.wait_done  = (wait_cnt == wait_last);
    assign ctl.end_weight = (round_cnt == max_round_weight_i);

    // loading stops once the last column word is read
    assert property (@(posedge clk_i) disable iff (sel_mux_tr_rst)
        ctl.load_done |=> !ctl.load_cnt_ld);

    // drain counter never runs past its terminal count
    assert property (@(posedge clk_i) disable iff (sel_mux_tr_rst)
        ctl.wait_done |=> !ctl.wait_cnt_ld);

endmodule

`default_nettype wire

// ==== src/sa_ctrl_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module sa_ctrl_fsm (
    input  wire     clk_i,
    input  wire     sel_mux_tr_rst,
    input  wire     halt_i,
    input  wire     end_feature_i,
    sa_ctrl_if.fsm  ctl,
    output logic    rst_o,
    output logic    load_o,
    output logic    ready_o,
    output logic    start_op_o,
    output logic    rd_feature_ld_o
);

    logic [sa_ctrl_pkg::ST_W-1:0] state;
    logic [sa_ctrl_pkg::ST_W-1:0] state_nxt;

    always_ff @(posedge clk_i or posedge sel_mux_tr_rst) begin
        if (sel_mux_tr_rst) begin
            state <= sa_ctrl_pkg::ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // next state
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_nxt = state;
        case (state)
            sa_ctrl_pkg::ST_IDLE: begin
                if (!halt_i && !ctl.end_weight) begin
                    state_nxt = sa_ctrl_pkg::ST_LOAD;
                end
            end
            sa_ctrl_pkg::ST_LOAD: begin
                if (ctl.load_done) begin
                    state_nxt = sa_ctrl_pkg::ST_READY;
                end
            end
            sa_ctrl_pkg::ST_READY: begin
                if (ctl.ready_done) begin
                    state_nxt = sa_ctrl_pkg::ST_START;
                end
            end
            sa_ctrl_pkg::ST_START: begin
                if (halt_i) begin
                    state_nxt = sa_ctrl_pkg::ST_IDLE;
                end else if (end_feature_i) begin
                    state_nxt = sa_ctrl_pkg::ST_WAIT;
                end
            end
            sa_ctrl_pkg::ST_WAIT: begin
                // last round drains back to idle and any other fetches the next weights
                if (halt_i) begin
                    state_nxt = sa_ctrl_pkg::ST_IDLE;
                end else if (ctl.wait_done) begin
                    state_nxt = ctl.end_weight ? sa_ctrl_pkg::ST_IDLE : sa_ctrl_pkg::ST_LOAD;
                end
            end
            default: state_nxt = sa_ctrl_pkg::ST_IDLE;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // moore decode
    ////////////////////////////////////////////////////////////////////////////

    assign rst_o           = (state == sa_ctrl_pkg::ST_IDLE);
    assign load_o          = (state == sa_ctrl_pkg::ST_LOAD);
    assign ready_o         = (state == sa_ctrl_pkg::ST_READY);
    assign start_op_o      = (state == sa_ctrl_pkg::ST_START) || (state == sa_ctrl_pkg::ST_WAIT);
    assign rd_feature_ld_o = ready_o || (state == sa_ctrl_pkg::ST_START);

    assign ctl.cfg_ld        = load_o;
    assign ctl.cfg_clr       = rst_o;
    assign ctl.load_cnt_ld   = load_o;
    assign ctl.load_cnt_clr  = !load_o;
    assign ctl.ready_cnt_ld  = ready_o;
    assign ctl.ready_cnt_clr = !ready_o;
    assign ctl.wait_cnt_ld   = (state == sa_ctrl_pkg::ST_WAIT);
    assign ctl.wait_cnt_clr  = (state != sa_ctrl_pkg::ST_WAIT);
    assign ctl.round_clr     = rst_o;
    // feature address runs through ready and start only
    assign ctl.feat_ld       = rd_feature_ld_o;
    assign ctl.feat_clr      = !rd_feature_ld_o;

    // phase counters flag their end only inside their own phase
    assert property (@(posedge clk_i) disable iff (sel_mux_tr_rst)
        ctl.load_done |-> load_o);

    assert property (@(posedge clk_i) disable iff (sel_mux_tr_rst)
        ctl.ready_done |-> ready_o);

endmodule

`default_nettype wire

// ==== src/sa_ctrl_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface sa_ctrl_if ();

    // strobes from the sequencer
    logic cfg_clr;
    logic cfg_ld;
    logic load_cnt_ld;
    logic load_cnt_clr;
    logic ready_cnt_ld;
    logic ready_cnt_clr;
    logic wait_cnt_ld;
    logic wait_cnt_clr;
    logic round_clr;
    logic feat_ld;
    logic feat_clr;

    // terminal flags back from the counters
    logic load_done;
    logic ready_done;
    logic wait_done;
    logic end_weight;

    modport fsm (
        output cfg_clr, cfg_ld, load_cnt_ld, load_cnt_clr, ready_cnt_ld, ready_cnt_clr,
               wait_cnt_ld, wait_cnt_clr, round_clr, feat_ld, feat_clr,
        input  load_done, ready_done, wait_done, end_weight
    );

    modport cnt (
        input  load_cnt_ld, load_cnt_clr, ready_cnt_ld, ready_cnt_clr,
               wait_cnt_ld, wait_cnt_clr, round_clr, feat_ld, feat_clr,
        output load_done, ready_done, wait_done, end_weight
    );

    modport cfg (
        input cfg_clr, cfg_ld
    );

endinterface

`default_nettype wire

// ==== src/sa_ctrl_pkg.sv ====
`default_nettype none

package sa_ctrl_pkg;

    // array geometry
    localparam int N_ROWS     = 4;
    localparam int N_COLS     = 4;
    localparam int N_FILT_MAX = 3;

    // per-row field widths
    localparam int SEL_W     = $clog2(N_FILT_MAX);
    localparam int NUM_COL_W = $clog2(N_FILT_MAX + 1);
    localparam int TR_SEL_W  = 2;

    // configuration word layout, rows packed low to high inside each field
    localparam int OFS_FSEL  = 0;
    localparam int OFS_NCOL  = OFS_FSEL + N_ROWS * SEL_W;
    localparam int OFS_TRSEL = OFS_NCOL + N_ROWS * NUM_COL_W;
    localparam int OFS_ENADD = OFS_TRSEL + N_ROWS * TR_SEL_W;
    localparam int ROM_W     = OFS_ENADD + N_ROWS;

    // counter widths
    localparam int ROUND_W     = 3;
    localparam int LOAD_W      = $clog2(N_COLS);
    localparam int READY_W     = 2;
    localparam int WAIT_W      = NUM_COL_W + 2;
    localparam int FEAT_ADDR_W = 5;
    localparam int ROM_ADDR_W  = ROUND_W + LOAD_W;

    // phase lengths
    localparam logic [LOAD_W-1:0]  LOAD_LAST  = LOAD_W'(N_COLS - 1);
    localparam logic [READY_W-1:0] READY_LAST = READY_W'(2);
    localparam logic [WAIT_W-1:0]  DRAIN_BASE = WAIT_W'(6);

    // sequencer states
    localparam int               ST_W     = 3;
    localparam logic [ST_W-1:0]  ST_IDLE  = 3'd0;
    localparam logic [ST_W-1:0]  ST_LOAD  = 3'd1;
    localparam logic [ST_W-1:0]  ST_READY = 3'd2;
    localparam logic [ST_W-1:0]  ST_START = 3'd3;
    localparam logic [ST_W-1:0]  ST_WAIT  = 3'd4;

endpackage

`default_nettype wire

// ==== src/sa_rom_cfg_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module sa_rom_cfg_regs (
    input  wire                                                     clk_i,
    input  wire                                                     sel_mux_tr_rst,
    sa_ctrl_if.cfg                                                  ctl,
    input  wire  [sa_ctrl_pkg::ROM_W-1:0]                           rom_signals_data_i,
    output logic [sa_ctrl_pkg::N_ROWS-1:0][sa_ctrl_pkg::SEL_W-1:0]     f_sel_o,
    output logic [sa_ctrl_pkg::N_ROWS-1:0][sa_ctrl_pkg::NUM_COL_W-1:0] number_of_columns_o,
    output logic [sa_ctrl_pkg::N_ROWS-1:0][sa_ctrl_pkg::TR_SEL_W-1:0]  sel_mux_tr_o,
    output logic [sa_ctrl_pkg::N_ROWS-1:0]                          en_adder_node_o
);

    logic [sa_ctrl_pkg::N_ROWS-1:0][sa_ctrl_pkg::SEL_W-1:0]     f_sel_w;
    logic [sa_ctrl_pkg::N_ROWS-1:0][sa_ctrl_pkg::NUM_COL_W-1:0] ncol_w;
    logic [sa_ctrl_pkg::N_ROWS-1:0][sa_ctrl_pkg::TR_SEL_W-1:0]  tr_sel_w;
    logic [sa_ctrl_pkg::N_ROWS-1:0]                             en_add_w;
    logic [sa_ctrl_pkg::N_ROWS-1:0][sa_ctrl_pkg::TR_SEL_W-1:0]  tr_sel_stage;

    // field slices of the current word
    assign f_sel_w = rom_signals_data_i[sa_ctrl_pkg::OFS_FSEL +:
                                        sa_ctrl_pkg::N_ROWS * sa_ctrl_pkg::SEL_W];
    assign ncol_w = rom_signals_data_i[sa_ctrl_pkg::OFS_NCOL +:
                                       sa_ctrl_pkg::N_ROWS * sa_ctrl_pkg::NUM_COL_W];
    assign tr_sel_w = rom_signals_data_i[sa_ctrl_pkg::OFS_TRSEL +:
                                         sa_ctrl_pkg::N_ROWS * sa_ctrl_pkg::TR_SEL_W];
    assign en_add_w = rom_signals_data_i[sa_ctrl_pkg::OFS_ENADD +: sa_ctrl_pkg::N_ROWS];

    always_ff @(posedge clk_i or posedge sel_mux_tr_rst) begin
        if (sel_mux_tr_rst) begin
            f_sel_o             <= '0;
            number_of_columns_o <= '0;
            en_adder_node_o     <= '0;
            tr_sel_stage        <= '0;
            sel_mux_tr_o        <= '0;
        end else if (ctl.cfg_clr) begin
            f_sel_o             <= '0;
            number_of_columns_o <= '0;
            en_adder_node_o     <= '0;
            tr_sel_stage        <= '0;
            sel_mux_tr_o        <= '0;
        end else if (ctl.cfg_ld) begin
            f_sel_o             <= f_sel_w;
            number_of_columns_o <= ncol_w;
            en_adder_node_o     <= en_add_w;
            // transfer select lags one word behind the rest
            tr_sel_stage        <= tr_sel_w;
            sel_mux_tr_o        <= tr_sel_stage;
        end
    end

endmodule

`default_nettype wire

// ==== src/sa_row_col_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module sa_row_col_gen (
    input  wire                                                     clk_i,
    input  wire                                                     sel_mux_tr_rst,
    sa_ctrl_if.cfg                                                  ctl,
    input  wire  [sa_ctrl_pkg::ROM_W-1:0]                           rom_signals_data_i,
    input  wire  [sa_ctrl_pkg::NUM_COL_W-1:0]                       filter_size_i,
    output logic [sa_ctrl_pkg::N_ROWS-1:0][sa_ctrl_pkg::NUM_COL_W-1:0] column_num_o,
    output logic [sa_ctrl_pkg::N_ROWS-1:0][sa_ctrl_pkg::NUM_COL_W-1:0] row_num_o,
    output logic [sa_ctrl_pkg::N_ROWS-1:0]                          sel_mux_node_o
);

    logic [sa_ctrl_pkg::N_ROWS-1:0][sa_ctrl_pkg::NUM_COL_W-1:0] ncol;
    logic [sa_ctrl_pkg::N_ROWS-1:0][sa_ctrl_pkg::NUM_COL_W-1:0] col_cnt;

    assign ncol = rom_signals_data_i[sa_ctrl_pkg::OFS_NCOL +:
                                     sa_ctrl_pkg::N_ROWS * sa_ctrl_pkg::NUM_COL_W];

    // column index counts down from ncol, wraps per row
    always_ff @(posedge clk_i or posedge sel_mux_tr_rst) begin
        if (sel_mux_tr_rst) begin
            col_cnt      <= '0;
            column_num_o <= '0;
        end else if (ctl.cfg_clr) begin
            col_cnt      <= '0;
            column_num_o <= '0;
        end else if (ctl.cfg_ld) begin
            for (int i = 0; i < sa_ctrl_pkg::N_ROWS; i++) begin
                column_num_o[i] <= ncol[i] - col_cnt[i];
                if (col_cnt[i] == ncol[i] - 1'b1) begin
                    col_cnt[i] <= '0;
                end else begin
                    col_cnt[i] <= col_cnt[i] + 1'b1;
                end
            end
        end
    end

    // row number is (i mod filter_size) + 1, last row of a filter closes the node
    always_comb begin
        logic [sa_ctrl_pkg::NUM_COL_W-1:0] b;
        logic [sa_ctrl_pkg::NUM_COL_W-1:0] row;
        b = '0;
        for (int i = 0; i < sa_ctrl_pkg::N_ROWS; i++) begin
            if (b == filter_size_i) begin
                b = '0;
            end
            row               = b + 1'b1;
            row_num_o[i]      = row;
            sel_mux_node_o[i] = (row != filter_size_i);
            b                 = b + 1'b1;
        end
    end

    for (genvar g = 0; g < sa_ctrl_pkg::N_ROWS; g++) begin : g_ncol_chk
        // a ROM word with zero columns would stall the wrap
        assert property (@(posedge clk_i) disable iff (sel_mux_tr_rst)
            ctl.cfg_ld |-> ncol[g] != '0);
    end

endmodule

`default_nettype wire

// ==== tests/tb_sa_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_sa_controller;

    localparam int SEED       = 69855;
    localparam int WAIT_LIMIT = 64;
    localparam int ROM_DEPTH  = 2 ** sa_ctrl_pkg::ROM_ADDR_W;
    localparam int FSEL_BITS  = sa_ctrl_pkg::N_ROWS * sa_ctrl_pkg::SEL_W;
    localparam int COLS_BITS  = sa_ctrl_pkg::N_ROWS * sa_ctrl_pkg::NUM_COL_W;
    localparam int TRSEL_BITS = sa_ctrl_pkg::N_ROWS * sa_ctrl_pkg::TR_SEL_W;

    typedef logic [sa_ctrl_pkg::ROM_W-1:0]                               word_t;
    typedef logic [sa_ctrl_pkg::N_ROWS-1:0][sa_ctrl_pkg::SEL_W-1:0]      fsel_t;
    typedef logic [sa_ctrl_pkg::N_ROWS-1:0][sa_ctrl_pkg::NUM_COL_W-1:0]  cols_t;
    typedef logic [sa_ctrl_pkg::N_ROWS-1:0][sa_ctrl_pkg::TR_SEL_W-1:0]   trsel_t;
    typedef logic [sa_ctrl_pkg::N_ROWS-1:0]                              rowbits_t;

    logic                                  clk_i = 1'b0;
    logic                                  sel_mux_tr_rst;
    logic                                  halt_i;
    logic                                  end_feature_i;
    logic [sa_ctrl_pkg::NUM_COL_W-1:0]     filter_size_i;
    logic [sa_ctrl_pkg::ROUND_W-1:0]       max_round_weight_i;
    word_t                                 rom_data;
    logic                                  rst_o;
    logic                                  load_o;
    logic                                  ready_o;
    logic                                  start_op_o;
    logic                                  rd_feature_ld_o;
    logic [sa_ctrl_pkg::ROM_ADDR_W-1:0]    addrs_rom_signal_o;
    logic [sa_ctrl_pkg::FEAT_ADDR_W-1:0]   in_feature_addr_o;
    fsel_t                                 f_sel_o;
    cols_t                                 number_of_columns_o;
    trsel_t                                sel_mux_tr_o;
    rowbits_t                              en_adder_node_o;
    cols_t                                 column_num_o;
    cols_t                                 row_num_o;
    rowbits_t                              sel_mux_node_o;

    word_t rom_mem [ROM_DEPTH];
    cols_t ref_cnt;

    always #5 clk_i = ~clk_i;

    // signal ROM, combinational read
    assign rom_data = rom_mem[addrs_rom_signal_o];

    sa_controller UUT (
        .clk_i               (clk_i),
        .sel_mux_tr_rst      (sel_mux_tr_rst),
        .halt_i              (halt_i),
        .end_feature_i       (end_feature_i),
        .filter_size_i       (filter_size_i),
        .max_round_weight_i  (max_round_weight_i),
        .rom_signals_data_i  (rom_data),
        .rst_o               (rst_o),
        .load_o              (load_o),
        .ready_o             (ready_o),
        .start_op_o          (start_op_o),
        .rd_feature_ld_o     (rd_feature_ld_o),
        .addrs_rom_signal_o  (addrs_rom_signal_o),
        .in_feature_addr_o   (in_feature_addr_o),
        .f_sel_o             (f_sel_o),
        .number_of_columns_o (number_of_columns_o),
        .sel_mux_tr_o        (sel_mux_tr_o),
        .en_adder_node_o     (en_adder_node_o),
        .column_num_o        (column_num_o),
        .row_num_o           (row_num_o),
        .sel_mux_node_o      (sel_mux_node_o)
    );

    ////////////////////////////////////////////////////////////////////////////
    // error reporting and compares
    ////////////////////////////////////////////////////////////////////////////

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input string exp_s, input string act_s);
        fail_now($sformatf("MISMATCH at %0t: %s expected %s, got %s",
                           $time, name, exp_s, act_s));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) report_mismatch(name, $sformatf("%b", exp), $sformatf("%b", act));
    endtask

    task automatic check_addr(input string name,
                              input logic [sa_ctrl_pkg::FEAT_ADDR_W-1:0] exp,
                              input logic [sa_ctrl_pkg::FEAT_ADDR_W-1:0] act);
        if (act !== exp) report_mismatch(name, $sformatf("%0d", exp), $sformatf("%0d", act));
    endtask

    task automatic check_len(input string name, input int exp, input int act);
        if (act != exp) report_mismatch(name, $sformatf("%0d", exp), $sformatf("%0d", act));
    endtask

    task automatic check_fsel(input string name, input fsel_t exp, input fsel_t act);
        if (act !== exp) report_mismatch(name, $sformatf("0x%h", exp), $sformatf("0x%h", act));
    endtask

    task automatic check_cols(input string name, input cols_t exp, input cols_t act);
        if (act !== exp) report_mismatch(name, $sformatf("0x%h", exp), $sformatf("0x%h", act));
    endtask

    task automatic check_trsel(input string name, input trsel_t exp, input trsel_t act);
        if (act !== exp) report_mismatch(name, $sformatf("0x%h", exp), $sformatf("0x%h", act));
    endtask

    task automatic check_rows(input string name, input rowbits_t exp, input rowbits_t act);
        if (act !== exp) report_mismatch(name, $sformatf("%b", exp), $sformatf("%b", act));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    // one load phase of a round, column counters carried across rounds
    function automatic void ref_load_phase(input int round, inout cols_t cnt,
                                           output fsel_t fsel, output cols_t ncol,
                                           output trsel_t trsel, output rowbits_t en,
                                           output cols_t colnum);
        word_t w;
        trsel  = '0;
        colnum = '0;
        for (int k = 0; k < sa_ctrl_pkg::N_COLS; k++) begin
            w    = rom_mem[round * sa_ctrl_pkg::N_COLS + k];
            fsel = FSEL_BITS'(w >> sa_ctrl_pkg::OFS_FSEL);
            ncol = COLS_BITS'(w >> sa_ctrl_pkg::OFS_NCOL);
            en   = sa_ctrl_pkg::N_ROWS'(w >> sa_ctrl_pkg::OFS_ENADD);
            // transfer select settles on the second-to-last word
            if (k == sa_ctrl_pkg::N_COLS - 2) begin
                trsel = TRSEL_BITS'(w >> sa_ctrl_pkg::OFS_TRSEL);
            end
            for (int i = 0; i < sa_ctrl_pkg::N_ROWS; i++) begin
                colnum[i] = ncol[i] - cnt[i];
                if (cnt[i] == ncol[i] - sa_ctrl_pkg::NUM_COL_W'(1)) begin
                    cnt[i] = '0;
                end else begin
                    cnt[i] = cnt[i] + sa_ctrl_pkg::NUM_COL_W'(1);
                end
            end
        end
    endfunction

    function automatic void ref_row_map(input int fs, output cols_t row, output rowbits_t node);
        for (int i = 0; i < sa_ctrl_pkg::N_ROWS; i++) begin
            row[i]  = sa_ctrl_pkg::NUM_COL_W'((i % fs) + 1);
            node[i] = ((i % fs) + 1) != fs;
        end
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic next_cycle();
        @(posedge clk_i);
        #1;
    endtask

    task automatic idle_checks();
        check_bit("rst_o", 1'b1, rst_o);
        check_bit("load_o", 1'b0, load_o);
        check_bit("ready_o", 1'b0, ready_o);
        check_bit("start_op_o", 1'b0, start_op_o);
        check_bit("rd_feature_ld_o", 1'b0, rd_feature_ld_o);
        check_fsel("f_sel_o", '0, f_sel_o);
        check_cols("number_of_columns_o", '0, number_of_columns_o);
        check_trsel("sel_mux_tr_o", '0, sel_mux_tr_o);
        check_rows("en_adder_node_o", '0, en_adder_node_o);
        check_cols("column_num_o", '0, column_num_o);
        check_addr("in_feature_addr_o", '0, in_feature_addr_o);
    endtask

    task automatic run_rounds(input int fs);
        int       rounds;
        int       t;
        int       n;
        int       j;
        int       slen;
        fsel_t    exp_fsel;
        cols_t    exp_ncol;
        trsel_t   exp_trsel;
        rowbits_t exp_en;
        cols_t    exp_colnum;
        cols_t    exp_row;
        rowbits_t exp_node;
        rounds             = fs + 1;
        filter_size_i      = sa_ctrl_pkg::NUM_COL_W'(fs);
        max_round_weight_i = sa_ctrl_pkg::ROUND_W'(rounds);
        ref_cnt            = '0;
        next_cycle();
        ref_row_map(fs, exp_row, exp_node);
        check_cols("row_num_o", exp_row, row_num_o);
        check_rows("sel_mux_node_o", exp_node, sel_mux_node_o);
        halt_i = 1'b0;
        for (int r = 0; r < rounds; r++) begin
            t = 0;
            while (!load_o) begin
                next_cycle();
                t++;
                if (t > WAIT_LIMIT) fail_now("timed out waiting for load_o");
            end
            n = 0;
            while (load_o) begin
                check_addr("addrs_rom_signal_o",
                           sa_ctrl_pkg::FEAT_ADDR_W'(r * sa_ctrl_pkg::N_COLS + n),
                           addrs_rom_signal_o);
                n++;
                next_cycle();
                if (n > WAIT_LIMIT) fail_now("load_o stuck high");
            end
            check_len("load_o cycles", sa_ctrl_pkg::N_COLS, n);
            ref_load_phase(r, ref_cnt, exp_fsel, exp_ncol, exp_trsel, exp_en, exp_colnum);
            check_fsel("f_sel_o", exp_fsel, f_sel_o);
            check_cols("number_of_columns_o", exp_ncol, number_of_columns_o);
            check_trsel("sel_mux_tr_o", exp_trsel, sel_mux_tr_o);
            check_rows("en_adder_node_o", exp_en, en_adder_node_o);
            check_cols("column_num_o", exp_colnum, column_num_o);
            // feature address counts every ready and start cycle
            n = 0;
            j = 0;
            while (ready_o) begin
                check_bit("rd_feature_ld_o", 1'b1, rd_feature_ld_o);
                check_addr("in_feature_addr_o", sa_ctrl_pkg::FEAT_ADDR_W'(j), in_feature_addr_o);
                n++;
                j++;
                next_cycle();
                if (n > WAIT_LIMIT) fail_now("ready_o stuck high");
            end
            check_len("ready_o cycles", 3, n);
            slen = $urandom_range(8, 1);
            for (int s = 0; s < slen; s++) begin
                check_bit("start_op_o", 1'b1, start_op_o);
                check_bit("rd_feature_ld_o", 1'b1, rd_feature_ld_o);
                check_addr("in_feature_addr_o", sa_ctrl_pkg::FEAT_ADDR_W'(j), in_feature_addr_o);
                end_feature_i = (s == slen - 1);
                j++;
                next_cycle();
            end
            end_feature_i = 1'b0;
            check_addr("in_feature_addr_o", sa_ctrl_pkg::FEAT_ADDR_W'(j), in_feature_addr_o);
            check_bit("rd_feature_ld_o", 1'b0, rd_feature_ld_o);
            n = 0;
            while (start_op_o && !load_o && !rst_o) begin
                n++;
                next_cycle();
                if (n > WAIT_LIMIT) fail_now("drain phase did not end");
            end
            check_len("drain cycles", 2 * (fs - 1) + 7, n);
            if (r < rounds - 1) begin
                check_bit("load_o", 1'b1, load_o);
            end else begin
                check_bit("rst_o", 1'b1, rst_o);
            end
        end
        // held halt keeps the sequencer parked in idle
        halt_i = 1'b1;
        next_cycle();
        for (int c = 0; c < 8; c++) begin
            idle_checks();
            next_cycle();
        end
    endtask

    initial begin
        int    seed_ret;
        word_t w;
        sel_mux_tr_rst     = 1'b1;
        halt_i             = 1'b1;
        end_feature_i      = 1'b0;
        filter_size_i      = sa_ctrl_pkg::NUM_COL_W'(1);
        max_round_weight_i = sa_ctrl_pkg::ROUND_W'(2);
        seed_ret = $urandom(SEED);
        // random words, every column-count field kept nonzero
        for (int a = 0; a < ROM_DEPTH; a++) begin
            w = sa_ctrl_pkg::ROM_W'($urandom);
            for (int i = 0; i < sa_ctrl_pkg::N_ROWS; i++) begin
                if (w[sa_ctrl_pkg::OFS_NCOL + i * sa_ctrl_pkg::NUM_COL_W +:
                      sa_ctrl_pkg::NUM_COL_W] == '0) begin
                    w[sa_ctrl_pkg::OFS_NCOL + i * sa_ctrl_pkg::NUM_COL_W] = 1'b1;
                end
            end
            rom_mem[a] = w;
        end
        repeat (16) @(posedge clk_i);
        #1;
        sel_mux_tr_rst = 1'b0;
        next_cycle();
        idle_checks();
        for (int fs = 1; fs <= sa_ctrl_pkg::N_FILT_MAX; fs++) begin
            run_rounds(fs);
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
